//--- dv/spi_regs_chk.sv
`include "spi_regs_defines.svh"
`default_nettype none

module spi_regs_chk
    import spi_regs_pkg::*;
(
    input wire             clk,
    input wire             rst,
    input wire spi_rx_t    rx,          // byte pulses from the driver
    input wire reg_req_t   req,
    input wire dec_phase_e phase_eff    // phase the decoder applies to rx
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////
    // write strobe
    ////////////////////
    a_we_src: assert property (@(posedge clk) disable iff (rst)
        req.we |-> $past(rx.valid && phase_eff == ph_wdata))    // only after a data byte
        else $error("write strobe without a data byte before it");

    a_we_rst: assert property (@(posedge clk) $past(rst) |-> !req.we)   // quiet in reset
        else $error("write strobe high during reset");

    // byte pulses from the driver
    a_rx_pulse: assert property (@(posedge clk) disable iff (rst) rx.valid |=> !rx.valid)
        else $error("rx valid high two cycles in a row");

endmodule

bind spi_cmd_decoder spi_regs_chk chk_i (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .req       (req),
    .phase_eff (phase_eff)
);

`default_nettype wire

//--- dv/spi_regs_stimulus.txt
// one record per line, op_addr_value in hex
// op 1 write, 2 read with expected value, 3 write cut after 4 data bits, 4 write plus extra byte, 0 ends
1_1_3c
1_6_c3
2_1_3c
2_6_c3
2_2_00  // untouched scratch
1_0_11  // id is read only
1_7_22  // count is read only
2_0_a5
3_3_77  // aborted write
2_3_00
1_3_99
2_3_99
4_4_5a  // trailing byte must not write
2_4_5a
2_5_00
2_7_04  // four accepted writes
0_0_00

//--- dv/spi_regs_tb.sv
`include "spi_regs_defines.svh"
`default_nettype none

module spi_regs_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF  = 8;       // clk per sclk half period
    localparam int DEPTH = 64;      // room for stimulus records

    logic clk;
    logic rst;
    logic cs;
    logic sclk;
    logic mosi;
    logic miso;

    logic [15:0]            stim [DEPTH];   // op nibble then addr nibble then value byte
    logic [`SPI_DATA_W-1:0] model_reg [8];  // expected register map with the write count in [7]
    int                     errors;
    int                     checks;

    spi_regs_top dut_i (.clk(clk), .rst(rst), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    ////////////////////
    // helpers
    ////////////////////
    // n rising edges and then 1 ns more so pins change away from the edge
    task automatic wait_clk(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic check_val(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one cs frame sending MSB first from bits[23]
    // rx_byte keeps the last 8 bits sampled
    task automatic run_frame(input logic [23:0] bits, input int nbits,
                             output logic [7:0] rx_byte);
        cs = 1'b0;
        wait_clk(HALF);
        for (int i = 0; i < nbits; i++) begin
            sclk = 1'b1;
            mosi = bits[23-i];              // master shifts on the rising edge
            wait_clk(HALF);
            sclk    = 1'b0;
            rx_byte = {rx_byte[6:0], miso}; // sampled on the falling edge
            wait_clk(HALF);
        end
        cs = 1'b1;
        wait_clk(4);                        // short gap so frames run back to back
    endtask

    // command byte then turnaround byte then data byte
    task automatic read_reg(input logic [2:0] addr, output logic [7:0] data);
        run_frame({1'b0, addr, 4'h0, 16'h0000}, 24, data);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        logic [7:0] rd;
        logic [3:0] op;
        logic [2:0] addr;
        logic [7:0] val;
        int         n_ops;

        errors = 0;
        checks = 0;
        n_ops  = 0;
        rst    = 1'b1;
        cs     = 1'b1;                      // bus idle
        sclk   = 1'b0;
        mosi   = 1'b0;
        for (int a = 0; a < 8; a++) begin
            model_reg[a] = 8'h00;
        end
        model_reg[0] = 8'hA5;               // identity value at address 0
        $readmemh("dv/spi_regs_stimulus.txt", stim);
        wait_clk(8);
        rst = 1'b0;
        wait_clk(4);

        // whole map straight after reset
        for (int a = 0; a < 8; a++) begin
            read_reg(3'(a), rd);
            check_val($sformatf("reset_read_addr%0d", a), model_reg[a], rd);
        end

        for (int i = 0; i < DEPTH; i++) begin
            if (^stim[i] === 1'bx || stim[i][15:12] == 4'h0) begin
                break;                      // end marker or end of file
            end
            op   = stim[i][15:12];
            addr = stim[i][10:8];
            val  = stim[i][7:0];
            n_ops++;
            case (op)
                4'h1, 4'h4: begin           // op 4 sends one byte past the frame format
                    run_frame({1'b1, addr, 4'h0, val, ~val}, (op == 4'h4) ? 24 : 16, rd);
                    if (addr != 3'd0 && addr != 3'd7) begin
                        model_reg[addr] = val;
                        model_reg[7]    = model_reg[7] + 8'd1;  // wraps at 256
                    end
                end
                4'h2: begin
                    read_reg(addr, rd);
                    check_val($sformatf("rec%0d_read_addr%0d_file", i, addr), val, rd);
                    check_val($sformatf("rec%0d_read_addr%0d_model", i, addr),
                              model_reg[addr], rd);
                end
                4'h3: run_frame({1'b1, addr, 4'h0, val, 8'h00}, 12, rd);  // cut mid data byte
                default: begin
                    errors++;
                    $display("stimulus record %0d has an unknown op %h", i, op);
                end
            endcase
        end
        if (n_ops == 0) begin
            errors++;
            $display("no stimulus records could be read from dv/spi_regs_stimulus.txt");
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/spi_regs_pkg.sv
rtl/spi_pin_sync.sv
rtl/spi_slave_driver.sv
rtl/spi_cmd_decoder.sv
rtl/spi_reg_bank.sv
rtl/spi_regs_top.sv
dv/spi_regs_chk.sv
dv/spi_regs_tb.sv

//--- rtl/spi_cmd_decoder.sv
`include "spi_regs_defines.svh"
`default_nettype none

module spi_cmd_decoder
    import spi_regs_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire spi_rx_t                rx,         // bytes from the driver
    input  wire logic [`SPI_DATA_W-1:0] rd_data,    // bank read port
    output reg_req_t                    req,        // write request to the bank
    output logic [`SPI_ADDR_W-1:0]      rd_addr,
    output logic [`SPI_DATA_W-1:0]      tx_data     // byte for the driver's idle buffer
);

    dec_phase_e             phase;
    dec_phase_e             phase_eff;      // phase used to interpret rx
    spi_cmd_e               op_q;           // opcode of the current frame
    logic [`SPI_ADDR_W-1:0] addr_q;         // address of the current frame
    logic                   we_q;
    logic [`SPI_DATA_W-1:0] wdata_q;

    // first byte of a frame is always a command
    assign phase_eff = rx.first ? ph_cmd : phase;

    ////////////////////
    // frame phase FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= ph_cmd;
            op_q  <= cmd_read;
            we_q  <= 1'b0;
        end else begin
            we_q <= 1'b0;                   // one cycle write strobe
            if (rx.valid) begin
                case (phase_eff)
                    ph_cmd: begin
                        op_q  <= spi_cmd_e'(rx.data[`SPI_DATA_W-1]);
                        phase <= rx.data[`SPI_DATA_W-1] ? ph_wdata : ph_turn;
                    end
                    ph_wdata: begin
                        we_q  <= 1'b1;      // data byte lands one clk later
                        phase <= ph_done;
                    end
                    ph_turn:  phase <= ph_rdata;    // dummy byte while read data loads
                    ph_rdata: phase <= ph_done;
                    default:  phase <= ph_done;     // trailing bytes ignored
                endcase
            end
        end
    end

    // address from the command byte and data from the write byte
    always_ff @(posedge clk) begin
        if (rx.valid && phase_eff == ph_cmd) begin
            addr_q <= rx.data[`SPI_DATA_W-2 -: `SPI_ADDR_W];    // bits 6:4
        end
        if (rx.valid && phase_eff == ph_wdata) begin
            wdata_q <= rx.data;
        end
    end

    ////////////////////
    // outputs
    ////////////////////
    assign req     = '{we: we_q, addr: addr_q, wdata: wdata_q};
    assign rd_addr = addr_q;

    // read data goes to the driver from the command byte on and zero outside a read
    assign tx_data = (op_q == cmd_read && phase != ph_cmd) ? rd_data : '0;

endmodule

`default_nettype wire

//--- rtl/spi_pin_sync.sv
`include "spi_regs_defines.svh"
`default_nettype none

module spi_pin_sync
    import spi_regs_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       spi_pins_t pins,      // async pins from the master
    output spi_pins_t pins_s                // clk domain copy
);

    // idle bus level, cs high so reset never fakes a frame start
    localparam spi_pins_t PINS_IDLE = '{cs: 1'b1, sclk: 1'b0, mosi: 1'b0};

    spi_pins_t sync_q [`SPI_SYNC_STAGES];   // stage 0 is closest to the pins

    ////////////////////
    // flop chain
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SPI_SYNC_STAGES; i++) begin
                sync_q[i] <= PINS_IDLE;
            end
        end else begin
            sync_q[0] <= pins;                      // first stage may go metastable
            for (int i = 1; i < `SPI_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];           // settle
            end
        end
    end

    assign pins_s = sync_q[`SPI_SYNC_STAGES-1];    // exactly SPI_SYNC_STAGES clk late

endmodule

`default_nettype wire

//--- rtl/spi_reg_bank.sv
`include "spi_regs_defines.svh"
`default_nettype none

module spi_reg_bank
    import spi_regs_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire reg_req_t               req,
    input  wire logic [`SPI_ADDR_W-1:0] rd_addr,
    output logic [`SPI_DATA_W-1:0]      rd_data     // combinational read
);

    localparam logic [`SPI_ADDR_W-1:0] ADDR_ID  = `SPI_ADDR_W'(0);    // identity, read only
    localparam logic [`SPI_ADDR_W-1:0] ADDR_CNT = `SPI_ADDR_W'(7);    // write count, read only

    logic [`SPI_DATA_W-1:0] scratch_q [1:6];
    logic [`SPI_DATA_W-1:0] wr_cnt_q;           // accepted writes, wraps at 256
    logic                   wr_ok;

    // writes to the read-only slots are dropped and not counted
    assign wr_ok = req.we && (req.addr != ADDR_ID) && (req.addr != ADDR_CNT);

    ////////////////////
    // write side
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= 6; i++) begin
                scratch_q[i] <= '0;
            end
            wr_cnt_q <= '0;
        end else if (wr_ok) begin
            scratch_q[req.addr] <= req.wdata;
            wr_cnt_q            <= wr_cnt_q + 1'b1;     // same clk as the write
        end
    end

    ////////////////////
    // read side
    ////////////////////
    always_comb begin
        case (rd_addr)
            ADDR_ID:  rd_data = `SPI_REGS_ID;
            ADDR_CNT: rd_data = wr_cnt_q;
            default:  rd_data = scratch_q[rd_addr];
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/spi_regs_defines.svh
`ifndef SPI_REGS_DEFINES_SVH
`define SPI_REGS_DEFINES_SVH

`default_nettype none

// spi byte and register map sizes
`define SPI_DATA_W      8       // bits per spi byte
`define SPI_ADDR_W      3       // eight registers
`define SPI_SYNC_STAGES 2       // flops per pin in the input synchronizer

// fixed value read back at address 0
`define SPI_REGS_ID     8'hA5

`default_nettype wire

`endif

//--- rtl/spi_regs_pkg.sv
`include "spi_regs_defines.svh"
`default_nettype none

package spi_regs_pkg;

    // raw pins and their synchronized copy
    typedef struct packed {
        logic cs;       // active low frame select
        logic sclk;
        logic mosi;
    } spi_pins_t;

    // byte handed from the driver to the decoder
    typedef struct packed {
        logic                   valid;  // one clk pulse
        logic                   first;  // first byte since cs fell
        logic [`SPI_DATA_W-1:0] data;
    } spi_rx_t;

    typedef enum logic [1:0] {st_idle, st_wait_sclk_1, st_wait_sclk_0} drv_state_e;

    // opcode lives in command bit 7
    typedef enum logic {cmd_read = 1'b0, cmd_write = 1'b1} spi_cmd_e;

    typedef enum logic [2:0] {ph_cmd, ph_wdata, ph_turn, ph_rdata, ph_done} dec_phase_e;

    // register write request
    typedef struct packed {
        logic                   we;
        logic [`SPI_ADDR_W-1:0] addr;
        logic [`SPI_DATA_W-1:0] wdata;
    } reg_req_t;

endpackage

`default_nettype wire

//--- rtl/spi_regs_top.sv
`include "spi_regs_defines.svh"
`default_nettype none

module spi_regs_top
    import spi_regs_pkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  cs,
    input  wire  sclk,
    input  wire  mosi,
    output logic miso
);

    spi_pins_t              pins;       // raw pins
    spi_pins_t              pins_s;     // synchronized
    spi_rx_t                rx;
    reg_req_t               req;
    logic [`SPI_DATA_W-1:0] tx_data;
    logic [`SPI_DATA_W-1:0] rd_data;
    logic [`SPI_ADDR_W-1:0] rd_addr;

    assign pins = '{cs: cs, sclk: sclk, mosi: mosi};

    spi_pin_sync sync_i (
        .clk    (clk),
        .rst    (rst),
        .pins   (pins),
        .pins_s (pins_s)
    );

    spi_slave_driver drv_i (
        .clk     (clk),
        .rst     (rst),
        .pins_s  (pins_s),
        .tx_data (tx_data),
        .rx      (rx),
        .miso    (miso)
    );

    spi_cmd_decoder dec_i (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rd_data (rd_data),
        .req     (req),
        .rd_addr (rd_addr),
        .tx_data (tx_data)
    );

    spi_reg_bank bank_i (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- rtl/spi_slave_driver.sv
`include "spi_regs_defines.svh"
`default_nettype none

module spi_slave_driver
    import spi_regs_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire spi_pins_t              pins_s,     // synchronized pins
    input  wire logic [`SPI_DATA_W-1:0] tx_data,    // next byte to send
    output spi_rx_t                     rx,         // received byte, valid pulses
    output logic                        miso
);

    localparam int CNT_W = $clog2(`SPI_DATA_W + 1);   // counts 0 .. SPI_DATA_W

    // two shift registers, one shifts while the other tracks tx_data
    logic [`SPI_DATA_W-1:0] shreg [2];
    logic                   sel;                // index of the working register
    logic                   wrk;
    logic                   ld;
    logic [CNT_W-1:0]       cnt;                // bits started in this byte
    logic                   first_q;            // no byte finished since cs fell
    logic                   sclk_fall;          // low seen while waiting for it
    drv_state_e             state;

    assign wrk       = sel;
    assign ld        = ~sel;
    assign sclk_fall = (state == st_wait_sclk_0) && !pins_s.sclk;

    ////////////////////
    // data path
    ////////////////////
    always_ff @(posedge clk) begin
        shreg[ld] <= tx_data;                   // idle buffer reloads every clk
        if (sclk_fall) begin
            // cpha 1 samples mosi on the falling edge
            shreg[wrk] <= {shreg[wrk][`SPI_DATA_W-2:0], pins_s.mosi};
        end
    end

    ////////////////////
    // bit sequencer
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            sel     <= 1'b0;
            cnt     <= '0;
            first_q <= 1'b0;
            miso    <= 1'b0;
            rx      <= '0;
        end else begin
            rx.valid <= 1'b0;                   // pulse only
            case (state)
                st_idle: begin
                    if (!pins_s.cs) begin       // frame start
                        sel     <= ~sel;        // freshly loaded buffer goes to work
                        cnt     <= '0;
                        first_q <= 1'b1;
                        state   <= st_wait_sclk_1;
                    end
                end
                st_wait_sclk_1: begin
                    if (pins_s.sclk) begin
                        miso  <= shreg[wrk][`SPI_DATA_W-1];     // drive on rising edge
                        cnt   <= cnt + 1'b1;
                        state <= st_wait_sclk_0;
                    end else if (pins_s.cs) begin
                        state <= st_idle;       // frame over, partial byte dropped
                    end
                end
                st_wait_sclk_0: begin
                    if (!pins_s.sclk) begin
                        if (cnt == CNT_W'(`SPI_DATA_W)) begin
                            // byte complete, hand it over and swap buffers
                            rx.valid <= 1'b1;
                            rx.first <= first_q;
                            rx.data  <= {shreg[wrk][`SPI_DATA_W-2:0], pins_s.mosi};
                            sel      <= ~sel;
                            cnt      <= '0;
                            first_q  <= 1'b0;
                        end
                        state <= st_wait_sclk_1;
                    end else if (pins_s.cs) begin
                        state <= st_idle;       // cs lost with sclk still high
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire
